// File: common/udp_loop_pkg.sv
// Frames arrive already parsed; one UDP header per frame, then 64-bit beats ending on last
package udp_loop_pkg;

  // Payload beat geometry
  localparam int data_width = 64;
  localparam int keep_width = data_width / 8;

  // TTL placed on every looped-back reply
  localparam logic [7:0] reply_ttl = 8'd64;

  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;

  // Received UDP header with the IP addresses it was carried with
  typedef struct packed {
    ip_addr_t    source_ip;
    ip_addr_t    dest_ip;
    udp_port_t   source_port;
    udp_port_t   dest_port;
    logic [15:0] length;
    logic [15:0] checksum;
  } udp_hdr_t;

  // Outgoing header, adds the IP time-to-live
  typedef struct packed {
    udp_hdr_t   hdr;
    logic [7:0] ttl;
  } tx_udp_hdr_t;

  // One payload beat; user marks a frame received with an error
  typedef struct packed {
    logic [data_width-1:0] data;
    logic [keep_width-1:0] keep;
    logic                  last;
    logic                  user;
  } payload_beat_t;

endpackage

// File: frame_buffer/stream_fifo.sv
// Holds up to depth words; a word written on one edge is visible the next cycle
`timescale 1ns/1ns

module stream_fifo #(
  parameter type item_t = logic,
  parameter int  depth  = 4
) (
  input  logic  clk_x8,
  input  logic  rst,
  input  item_t in_item,
  input  logic  in_valid,
  output logic  in_ready,
  output item_t out_item,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int aw = (depth > 1) ? $clog2(depth) : 1;

  item_t         mem [depth];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [aw:0]   count;
  logic [aw:0]   level;
  logic          wr;
  logic          load_out;
  logic          push;
  logic          pop;

  function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] ptr);
    next_ptr = (ptr == aw'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Output register counts as one slot
  assign level    = count + {{aw{1'b0}}, out_valid};
  assign in_ready = level < (aw + 1)'(depth);
  assign wr       = in_valid && in_ready;
  assign load_out = !out_valid || out_ready;

  // Bypass straight into the output register when storage is empty
  assign pop  = load_out && (count != '0);
  assign push = wr && !(load_out && (count == '0));

  always_ff @(posedge clk_x8) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + {{aw{1'b0}}, push} - {{aw{1'b0}}, pop};
      if (load_out) begin
        out_valid <= pop || wr;
      end
    end
  end

  always_ff @(posedge clk_x8) begin
    if (push) begin
      mem[wr_ptr] <= in_item;
    end
    if (pop) begin
      out_item <= mem[rd_ptr];
    end else if (load_out && wr) begin
      out_item <= in_item;
    end
  end

endmodule

// File: frame_buffer/frame_buffer.sv
// Header and payload queues run independently; frames stay aligned by header-then-beats order
`timescale 1ns/1ns

module frame_buffer
  import udp_loop_pkg::*;
#(
  parameter int hdr_depth     = 4,
  parameter int payload_depth = 64
) (
  input  logic          clk_x8,
  input  logic          rst,

  input  udp_hdr_t      buf_hdr,
  input  logic          buf_hdr_valid,
  output logic          buf_hdr_ready,
  input  payload_beat_t buf_payload,
  input  logic          buf_payload_valid,
  output logic          buf_payload_ready,

  output udp_hdr_t      out_hdr,
  output logic          out_hdr_valid,
  input  logic          out_hdr_ready,
  output payload_beat_t out_payload,
  output logic          out_payload_valid,
  input  logic          out_payload_ready
);

  // Headers of matched frames
  stream_fifo #(
    .item_t (udp_hdr_t),
    .depth  (hdr_depth)
  ) hdr_fifo_i (
    .clk_x8    (clk_x8),
    .rst       (rst),
    .in_item   (buf_hdr),
    .in_valid  (buf_hdr_valid),
    .in_ready  (buf_hdr_ready),
    .out_item  (out_hdr),
    .out_valid (out_hdr_valid),
    .out_ready (out_hdr_ready)
  );

  // Payload beats of matched frames
  stream_fifo #(
    .item_t (payload_beat_t),
    .depth  (payload_depth)
  ) payload_fifo_i (
    .clk_x8    (clk_x8),
    .rst       (rst),
    .in_item   (buf_payload),
    .in_valid  (buf_payload_valid),
    .in_ready  (buf_payload_ready),
    .out_item  (out_payload),
    .out_valid (out_payload_valid),
    .out_ready (out_payload_ready)
  );

endmodule

// File: hdl/udp_port_filter.sv
// Matching frames pass through with no delay; a non-matching payload is drained at full rate
`timescale 1ns/1ns

module udp_port_filter
  import udp_loop_pkg::*;
#(
  parameter udp_port_t match_port = 16'd1234
) (
  input  logic          clk_x8,
  input  logic          rst,

  input  udp_hdr_t      rx_hdr,
  input  logic          rx_hdr_valid,
  output logic          rx_hdr_ready,
  input  payload_beat_t rx_payload,
  input  logic          rx_payload_valid,
  output logic          rx_payload_ready,

  output udp_hdr_t      buf_hdr,
  output logic          buf_hdr_valid,
  input  logic          buf_hdr_ready,
  output payload_beat_t buf_payload,
  output logic          buf_payload_valid,
  input  logic          buf_payload_ready
);

  typedef enum logic {
    st_idle,
    st_payload
  } state_t;

  state_t state;
  logic   match_reg;
  logic   hdr_match;
  logic   hdr_xfer;
  logic   last_xfer;

  assign hdr_match = rx_hdr.dest_port == match_port;

  // Header side, only taken between frames
  assign rx_hdr_ready  = (state == st_idle) && (!hdr_match || buf_hdr_ready);
  assign buf_hdr       = rx_hdr;
  assign buf_hdr_valid = (state == st_idle) && rx_hdr_valid && hdr_match;
  assign hdr_xfer      = rx_hdr_valid && rx_hdr_ready;

  // Payload goes to the buffer or is dropped
  assign buf_payload       = rx_payload;
  assign buf_payload_valid = (state == st_payload) && match_reg && rx_payload_valid;

  always_comb begin
    if (state != st_payload) begin
      rx_payload_ready = 1'b0;
    end else if (match_reg) begin
      rx_payload_ready = buf_payload_ready;
    end else begin
      rx_payload_ready = 1'b1;
    end
  end

  assign last_xfer = rx_payload_valid && rx_payload_ready && rx_payload.last;

  always_ff @(posedge clk_x8) begin
    if (rst) begin
      state     <= st_idle;
      match_reg <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (hdr_xfer) begin
            state     <= st_payload;
            match_reg <= hdr_match;
          end
        end
        st_payload: begin
          if (last_xfer) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

// File: hdl/udp_loopback_tx.sv
// Reply checksum is left at zero; led shows the low data byte of each reply's first beat
`timescale 1ns/1ns

module udp_loopback_tx
  import udp_loop_pkg::*;
#(
  parameter ip_addr_t local_ip = {8'd22, 8'd1, 8'd212, 8'd10}
) (
  input  logic          clk_x8,
  input  logic          rst,

  input  udp_hdr_t      out_hdr,
  input  logic          out_hdr_valid,
  output logic          out_hdr_ready,
  input  payload_beat_t out_payload,
  input  logic          out_payload_valid,
  output logic          out_payload_ready,

  output tx_udp_hdr_t   tx_hdr,
  output logic          tx_hdr_valid,
  input  logic          tx_hdr_ready,
  output payload_beat_t tx_payload,
  output logic          tx_payload_valid,
  input  logic          tx_payload_ready,

  output logic [7:0]    led
);

  logic sending;
  logic first_beat;
  logic hdr_xfer;
  logic beat_xfer;

  // Reply header built from the stored one
  always_comb begin
    tx_hdr.hdr.source_ip   = local_ip;
    tx_hdr.hdr.dest_ip     = out_hdr.source_ip;
    tx_hdr.hdr.source_port = out_hdr.dest_port;
    tx_hdr.hdr.dest_port   = out_hdr.source_port;
    tx_hdr.hdr.length      = out_hdr.length;
    tx_hdr.hdr.checksum    = 16'd0;
    tx_hdr.ttl             = reply_ttl;
  end

  // Header only between frames, beats only after it
  assign tx_hdr_valid  = !sending && out_hdr_valid;
  assign out_hdr_ready = !sending && tx_hdr_ready;
  assign hdr_xfer      = tx_hdr_valid && tx_hdr_ready;

  assign tx_payload        = out_payload;
  assign tx_payload_valid  = sending && out_payload_valid;
  assign out_payload_ready = sending && tx_payload_ready;
  assign beat_xfer         = tx_payload_valid && tx_payload_ready;

  always_ff @(posedge clk_x8) begin
    if (rst) begin
      sending <= 1'b0;
    end else if (hdr_xfer) begin
      sending <= 1'b1;
    end else if (beat_xfer && tx_payload.last) begin
      sending <= 1'b0;
    end
  end

  // First beat of each frame drives the LEDs
  always_ff @(posedge clk_x8) begin
    if (rst) begin
      first_beat <= 1'b1;
      led        <= 8'd0;
    end else if (beat_xfer) begin
      first_beat <= tx_payload.last;
      if (first_beat) begin
        led <= tx_payload.data[7:0];
      end
    end
  end

endmodule

// File: hdl/udp_loopback_top.sv
// Single clock domain; only frames to match_port are returned, all others are dropped
`timescale 1ns/1ns

module udp_loopback_top
  import udp_loop_pkg::*;
#(
  parameter udp_port_t match_port    = 16'd1234,
  parameter ip_addr_t  local_ip      = {8'd22, 8'd1, 8'd212, 8'd10},
  parameter int        hdr_depth     = 4,
  parameter int        payload_depth = 64
) (
  input  logic          clk_x8,
  input  logic          rst,

  input  udp_hdr_t      rx_hdr,
  input  logic          rx_hdr_valid,
  output logic          rx_hdr_ready,
  input  payload_beat_t rx_payload,
  input  logic          rx_payload_valid,
  output logic          rx_payload_ready,

  output tx_udp_hdr_t   tx_hdr,
  output logic          tx_hdr_valid,
  input  logic          tx_hdr_ready,
  output payload_beat_t tx_payload,
  output logic          tx_payload_valid,
  input  logic          tx_payload_ready,

  output logic [7:0]    led
);

  udp_hdr_t      buf_hdr;
  logic          buf_hdr_valid;
  logic          buf_hdr_ready;
  payload_beat_t buf_payload;
  logic          buf_payload_valid;
  logic          buf_payload_ready;

  udp_hdr_t      out_hdr;
  logic          out_hdr_valid;
  logic          out_hdr_ready;
  payload_beat_t out_payload;
  logic          out_payload_valid;
  logic          out_payload_ready;

  udp_port_filter #(
    .match_port (match_port)
  ) udp_port_filter_i (
    .clk_x8            (clk_x8),
    .rst               (rst),
    .rx_hdr            (rx_hdr),
    .rx_hdr_valid      (rx_hdr_valid),
    .rx_hdr_ready      (rx_hdr_ready),
    .rx_payload        (rx_payload),
    .rx_payload_valid  (rx_payload_valid),
    .rx_payload_ready  (rx_payload_ready),
    .buf_hdr           (buf_hdr),
    .buf_hdr_valid     (buf_hdr_valid),
    .buf_hdr_ready     (buf_hdr_ready),
    .buf_payload       (buf_payload),
    .buf_payload_valid (buf_payload_valid),
    .buf_payload_ready (buf_payload_ready)
  );

  frame_buffer #(
    .hdr_depth     (hdr_depth),
    .payload_depth (payload_depth)
  ) frame_buffer_i (
    .clk_x8            (clk_x8),
    .rst               (rst),
    .buf_hdr           (buf_hdr),
    .buf_hdr_valid     (buf_hdr_valid),
    .buf_hdr_ready     (buf_hdr_ready),
    .buf_payload       (buf_payload),
    .buf_payload_valid (buf_payload_valid),
    .buf_payload_ready (buf_payload_ready),
    .out_hdr           (out_hdr),
    .out_hdr_valid     (out_hdr_valid),
    .out_hdr_ready     (out_hdr_ready),
    .out_payload       (out_payload),
    .out_payload_valid (out_payload_valid),
    .out_payload_ready (out_payload_ready)
  );

  udp_loopback_tx #(
    .local_ip (local_ip)
  ) udp_loopback_tx_i (
    .clk_x8            (clk_x8),
    .rst               (rst),
    .out_hdr           (out_hdr),
    .out_hdr_valid     (out_hdr_valid),
    .out_hdr_ready     (out_hdr_ready),
    .out_payload       (out_payload),
    .out_payload_valid (out_payload_valid),
    .out_payload_ready (out_payload_ready),
    .tx_hdr            (tx_hdr),
    .tx_hdr_valid      (tx_hdr_valid),
    .tx_hdr_ready      (tx_hdr_ready),
    .tx_payload        (tx_payload),
    .tx_payload_valid  (tx_payload_valid),
    .tx_payload_ready  (tx_payload_ready),
    .led               (led)
  );

endmodule

// File: tests/udp_frame_model.svh
// Include inside the testbench module after match_port and local_ip; whole frames, in order
`ifndef UDP_FRAME_MODEL_SVH
`define UDP_FRAME_MODEL_SVH

// Replies the DUT still owes, oldest first
tx_udp_hdr_t   exp_hdr_q[$];
payload_beat_t exp_beat_q[$];
int            match_count = 0;
int            drop_count  = 0;

// Reply header as the loopback path must build it
function automatic tx_udp_hdr_t reply_header(input udp_hdr_t rx);
  tx_udp_hdr_t reply;
  reply.hdr.source_ip   = local_ip;
  reply.hdr.dest_ip     = rx.source_ip;
  reply.hdr.source_port = rx.dest_port;
  reply.hdr.dest_port   = rx.source_port;
  reply.hdr.length      = rx.length;
  reply.hdr.checksum    = 16'h0000;
  reply.ttl             = 8'd64;
  return reply;
endfunction

// Header taken by the DUT; looped tells whether the frame comes back
task automatic accept_header(input udp_hdr_t rx, output bit looped);
  looped = (rx.dest_port == match_port);
  if (looped) begin
    exp_hdr_q.push_back(reply_header(rx));
    match_count++;
  end else begin
    drop_count++;
  end
endtask

// Beats of dropped frames are never expected back
task automatic record_beat(input payload_beat_t beat, input bit looped);
  if (looped) begin
    exp_beat_q.push_back(beat);
  end
endtask

`endif

// File: tests/udp_loopback_tb.sv
// Random frames from a fixed seed; about half match the port; tx ready low about 30% of cycles
`timescale 1ns/1ns

module udp_loopback_tb
  import udp_loop_pkg::*;
();

  localparam udp_port_t match_port  = 16'd1234;
  localparam ip_addr_t  local_ip    = {8'd22, 8'd1, 8'd212, 8'd10};
  localparam int        frame_count = 200;
  localparam int        max_beats   = 8;
  localparam int        cycle_limit = frame_count * max_beats * 4 + 1000;

  logic          clk_x8;
  logic          rst;
  udp_hdr_t      rx_hdr;
  logic          rx_hdr_valid;
  logic          rx_hdr_ready;
  payload_beat_t rx_payload;
  logic          rx_payload_valid;
  logic          rx_payload_ready;
  tx_udp_hdr_t   tx_hdr;
  logic          tx_hdr_valid;
  logic          tx_hdr_ready;
  payload_beat_t tx_payload;
  logic          tx_payload_valid;
  logic          tx_payload_ready;
  logic [7:0]    led;

  integer        seed = 33;
  int            cycles = 0;
  int            error_count = 0;
  int            reset_errors = 0;
  int            hdr_errors = 0;
  int            beat_errors = 0;
  int            led_errors = 0;
  int            count_errors = 0;
  int            tx_hdr_count = 0;
  int            beat_count = 0;
  int            led_checks = 0;
  bit            tx_sending = 1'b0;
  bit            tx_first = 1'b0;
  bit            led_pending = 1'b0;
  logic [7:0]    led_exp;
  tx_udp_hdr_t   exp_hdr;
  payload_beat_t exp_beat;

  `include "udp_frame_model.svh"

  udp_loopback_top #(
    .match_port    (match_port),
    .local_ip      (local_ip),
    .hdr_depth     (4),
    .payload_depth (64)
  ) udp_loopback_top_i (
    .clk_x8           (clk_x8),
    .rst              (rst),
    .rx_hdr           (rx_hdr),
    .rx_hdr_valid     (rx_hdr_valid),
    .rx_hdr_ready     (rx_hdr_ready),
    .rx_payload       (rx_payload),
    .rx_payload_valid (rx_payload_valid),
    .rx_payload_ready (rx_payload_ready),
    .tx_hdr           (tx_hdr),
    .tx_hdr_valid     (tx_hdr_valid),
    .tx_hdr_ready     (tx_hdr_ready),
    .tx_payload       (tx_payload),
    .tx_payload_valid (tx_payload_valid),
    .tx_payload_ready (tx_payload_ready),
    .led              (led)
  );

  task automatic report_mismatch(inout int errors, input string name,
                                 input logic [63:0] got, input logic [63:0] exp);
    $display("** Error %s: got %h, expected %h", name, got, exp);
    errors++;
    error_count++;
  endtask

  task automatic report_failure(inout int errors, input string msg);
    $display("%s", msg);
    errors++;
    error_count++;
  endtask

  // Random idle cycles before a transfer is offered
  task automatic idle_randomly();
    while (({$random(seed)} % 4) == 0) begin
      @(posedge clk_x8);
      #1;
    end
  endtask

  // Ready is sampled mid-cycle; the transfer lands on the next rising edge
  task automatic send_header(input udp_hdr_t hdr, output bit looped);
    idle_randomly();
    rx_hdr       = hdr;
    rx_hdr_valid = 1'b1;
    @(negedge clk_x8);
    while (!rx_hdr_ready) begin
      @(negedge clk_x8);
    end
    accept_header(hdr, looped);
    @(posedge clk_x8);
    #1;
    rx_hdr_valid = 1'b0;
  endtask

  task automatic send_beat(input payload_beat_t beat, input bit looped);
    idle_randomly();
    rx_payload       = beat;
    rx_payload_valid = 1'b1;
    @(negedge clk_x8);
    while (!rx_payload_ready) begin
      @(negedge clk_x8);
    end
    record_beat(beat, looped);
    @(posedge clk_x8);
    #1;
    rx_payload_valid = 1'b0;
  endtask

  initial begin
    clk_x8 = 1'b0;
    forever #2 clk_x8 = ~clk_x8;
  end

  initial begin
    while (cycles < cycle_limit) begin
      @(posedge clk_x8);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", cycle_limit);
    $display("TEST FAILED");
    $finish;
  end

  // Consumer stalls, about 30 percent
  initial begin
    @(negedge rst);
    forever begin
      @(posedge clk_x8);
      #1;
      tx_hdr_ready     = ({$random(seed)} % 10) >= 3;
      tx_payload_ready = ({$random(seed)} % 10) >= 3;
    end
  end

  // Output monitor, sampled mid-cycle when the handshake is stable
  always @(negedge clk_x8) begin
    if (led_pending) begin
      led_checks++;
      if (led !== led_exp) begin
        report_mismatch(led_errors, "led", led, led_exp);
      end
      led_pending = 1'b0;
    end
    if (!rst && tx_hdr_valid && tx_hdr_ready) begin
      tx_hdr_count++;
      if (tx_sending) begin
        report_failure(hdr_errors, "A tx header came out before the previous frame ended");
      end
      if (exp_hdr_q.size() == 0) begin
        report_failure(hdr_errors, "A tx header came out with no matching frame sent");
      end else begin
        exp_hdr = exp_hdr_q.pop_front();
        if (tx_hdr.hdr.source_ip !== exp_hdr.hdr.source_ip) begin
          report_mismatch(hdr_errors, "tx_hdr.source_ip", tx_hdr.hdr.source_ip,
                          exp_hdr.hdr.source_ip);
        end
        if (tx_hdr.hdr.dest_ip !== exp_hdr.hdr.dest_ip) begin
          report_mismatch(hdr_errors, "tx_hdr.dest_ip", tx_hdr.hdr.dest_ip,
                          exp_hdr.hdr.dest_ip);
        end
        if (tx_hdr.hdr.source_port !== exp_hdr.hdr.source_port) begin
          report_mismatch(hdr_errors, "tx_hdr.source_port", tx_hdr.hdr.source_port,
                          exp_hdr.hdr.source_port);
        end
        if (tx_hdr.hdr.dest_port !== exp_hdr.hdr.dest_port) begin
          report_mismatch(hdr_errors, "tx_hdr.dest_port", tx_hdr.hdr.dest_port,
                          exp_hdr.hdr.dest_port);
        end
        if (tx_hdr.hdr.length !== exp_hdr.hdr.length) begin
          report_mismatch(hdr_errors, "tx_hdr.length", tx_hdr.hdr.length, exp_hdr.hdr.length);
        end
        if (tx_hdr.hdr.checksum !== exp_hdr.hdr.checksum) begin
          report_mismatch(hdr_errors, "tx_hdr.checksum", tx_hdr.hdr.checksum,
                          exp_hdr.hdr.checksum);
        end
        if (tx_hdr.ttl !== exp_hdr.ttl) begin
          report_mismatch(hdr_errors, "tx_hdr.ttl", tx_hdr.ttl, exp_hdr.ttl);
        end
      end
      tx_sending = 1'b1;
      tx_first   = 1'b1;
    end
    if (!rst && tx_payload_valid && tx_payload_ready) begin
      beat_count++;
      if (!tx_sending) begin
        report_failure(beat_errors, "A tx payload beat came out before its header");
      end
      if (exp_beat_q.size() == 0) begin
        report_failure(beat_errors, "A tx payload beat came out with none expected");
      end else begin
        exp_beat = exp_beat_q.pop_front();
        if (tx_payload.data !== exp_beat.data) begin
          report_mismatch(beat_errors, "tx_payload.data", tx_payload.data, exp_beat.data);
        end
        if (tx_payload.keep !== exp_beat.keep) begin
          report_mismatch(beat_errors, "tx_payload.keep", tx_payload.keep, exp_beat.keep);
        end
        if (tx_payload.last !== exp_beat.last) begin
          report_mismatch(beat_errors, "tx_payload.last", tx_payload.last, exp_beat.last);
        end
        if (tx_payload.user !== exp_beat.user) begin
          report_mismatch(beat_errors, "tx_payload.user", tx_payload.user, exp_beat.user);
        end
        if (tx_first) begin
          led_exp     = exp_beat.data[7:0];
          led_pending = 1'b1;
        end
      end
      tx_first = 1'b0;
      if (tx_payload.last) begin
        tx_sending = 1'b0;
      end
    end
  end

  initial begin : stimulus
    udp_hdr_t      hdr;
    payload_beat_t beat;
    int            nbeats;
    bit            looped;

    rst              = 1'b1;
    rx_hdr           = '0;
    // Matching port, so rx_hdr_ready also reflects the header FIFO
    rx_hdr.dest_port = match_port;
    rx_hdr_valid     = 1'b0;
    rx_payload       = '0;
    rx_payload_valid = 1'b0;
    tx_hdr_ready     = 1'b0;
    tx_payload_ready = 1'b0;
    repeat (5) @(posedge clk_x8);
    #1;
    rst = 1'b0;

    @(negedge clk_x8);
    if (tx_hdr_valid !== 1'b0) begin
      report_mismatch(reset_errors, "tx_hdr_valid", tx_hdr_valid, 1'b0);
    end
    if (tx_payload_valid !== 1'b0) begin
      report_mismatch(reset_errors, "tx_payload_valid", tx_payload_valid, 1'b0);
    end
    if (rx_hdr_ready !== 1'b1) begin
      report_mismatch(reset_errors, "rx_hdr_ready", rx_hdr_ready, 1'b1);
    end
    if (led !== 8'd0) begin
      report_mismatch(reset_errors, "led", led, 8'd0);
    end
    $display("reset_state: %0d errors", reset_errors);
    @(posedge clk_x8);
    #1;

    for (int f = 0; f < frame_count; f++) begin
      hdr.source_ip   = $random(seed);
      hdr.dest_ip     = $random(seed);
      hdr.source_port = $random(seed);
      hdr.dest_port   = $random(seed);
      hdr.length      = $random(seed);
      hdr.checksum    = $random(seed);
      if (($random(seed) & 1) == 1) begin
        hdr.dest_port = match_port;
      end else if (hdr.dest_port == match_port) begin
        hdr.dest_port = match_port ^ 16'h0001;
      end
      nbeats = 1 + ({$random(seed)} % max_beats);
      send_header(hdr, looped);
      for (int b = 0; b < nbeats; b++) begin
        beat.data = {$random(seed), $random(seed)};
        beat.last = (b == nbeats - 1);
        beat.keep = beat.last ? (8'hff >> ({$random(seed)} % 8)) : 8'hff;
        beat.user = (({$random(seed)} % 16) == 0);
        send_beat(beat, looped);
      end
    end

    // Let the buffered replies drain
    while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
      @(posedge clk_x8);
    end
    repeat (4) @(posedge clk_x8);

    if (tx_hdr_count != match_count) begin
      report_mismatch(count_errors, "tx header count", tx_hdr_count, match_count);
    end
    $display("header_rewrite: %0d headers, %0d errors", tx_hdr_count, hdr_errors);
    $display("payload_order: %0d beats, %0d errors", beat_count, beat_errors);
    $display("led_latch: %0d checks, %0d errors", led_checks, led_errors);
    $display("frame_counts: %0d matched, %0d dropped, %0d errors",
             match_count, drop_count, count_errors);
    $display("Summary: %0d checks, %0d errors",
             2 + tx_hdr_count + beat_count + led_checks, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: udp_loopback_top.f
+incdir+tests
common/udp_loop_pkg.sv
frame_buffer/stream_fifo.sv
frame_buffer/frame_buffer.sv
hdl/udp_port_filter.sv
hdl/udp_loopback_tx.sv
hdl/udp_loopback_top.sv
tests/udp_loopback_tb.sv

// File: Bender.yml
package:
  name: udp_loopback

sources:
  - files:
      - common/udp_loop_pkg.sv
      - frame_buffer/stream_fifo.sv
      - frame_buffer/frame_buffer.sv
      - hdl/udp_port_filter.sv
      - hdl/udp_loopback_tx.sv
      - hdl/udp_loopback_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/udp_loopback_tb.sv
